/* test/simon_testdata.txt */
# op key block expected, all hex except op
# op 0 encrypts, 1 decrypts, 2 only loads the key
0 1918111009080100 65656877 c69be9bb
1 1918111009080100 c69be9bb 65656877
0 1918111009080100 65656877 c69be9bb
0 1918111009080100 65656877 c69be9bb
1 1918111009080100 c69be9bb 65656877
1 1918111009080100 c69be9bb 65656877
2 0f0e0d0c0b0a0908 00000000 00000000
1 1918111009080100 c69be9bb 65656877
0 1918111009080100 65656877 c69be9bb
1 1918111009080100 c69be9bb 65656877

/* all.f */
+incdir+include
design/simonPkg.sv
design/blockIf.sv
design/simonKeySchedule.sv
design/simonBlockFifo.sv
design/simonRoundEngine.sv
design/simonCore.sv
test/simonCoreTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = simonCoreTb
FILELIST = all.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJDIR)

/* test/simonCoreTb.sv */
`timescale 1ns/1ps
`include "simon_cfg.svh"

module simonCoreTb;

	localparam int blkBits = 2 * `SIMON_WORD;
	localparam int keyBits = `SIMON_KEY_WORDS * `SIMON_WORD;

	logic clkAll;
	logic nR;
	logic keyValid;
	logic keyReady;
	logic [keyBits-1:0] key;
	logic inValid;
	logic inReady;
	logic [blkBits-1:0] inData;
	logic inDecrypt;
	logic outValid;
	logic outReady;
	logic [blkBits-1:0] outData;

	// Vectors from the data file where op 2 only loads its key
	int vecOp[$];
	logic [keyBits-1:0] vecKey[$];
	logic [blkBits-1:0] vecBlk[$];
	logic [blkBits-1:0] vecExp[$];
	logic [blkBits-1:0] expQ[$];
	string nameQ[$];

	integer seed = 32'h5483;
	int keyCount = 0;
	int blockCount = 0;
	int checkedCount = 0;
	int mismatchCount = 0;
	int otherCount = 0;
	bit fullSeen = 1'b0;
	bit vectorsRead = 1'b0;

	simonCore i_simonCore
	(
		.clkAll(clkAll),
		.nR(nR),
		.keyValid(keyValid),
		.keyReady(keyReady),
		.key(key),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.inDecrypt(inDecrypt),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

	initial
	begin
		clkAll = 1'b0;
		forever #50 clkAll = ~clkAll;
	end

	task automatic readVectors();
		int fd;
		int got;
		int op;
		string lineBuf;
		logic [keyBits-1:0] k;
		logic [blkBits-1:0] blk;
		logic [blkBits-1:0] expd;
		fd = $fopen("test/simon_testdata.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("Could not open test/simon_testdata.txt");
			otherCount++;
		end
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			lineBuf = "";
			void'($fgets(lineBuf, fd));
			if (lineBuf.len() > 0 && lineBuf.getc(0) != "#")
			begin
				got = $sscanf(lineBuf, "%d %h %h %h", op, k, blk, expd);
				if (got == 4)
				begin
					if (vecKey.size() == 0 || k != vecKey[$])
						keyCount++;
					if (op != 2)
						blockCount++;
					vecOp.push_back(op);
					vecKey.push_back(k);
					vecBlk.push_back(blk);
					vecExp.push_back(expd);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic loadKey(input logic [keyBits-1:0] k);
		// Engine must be idle before a key change
		while (expQ.size() != 0)
			@(negedge clkAll);
		keyValid = 1'b1;
		key = k;
		@(posedge clkAll);
		while (!keyReady)
			@(posedge clkAll);
		@(negedge clkAll);
		keyValid = 1'b0;
		assert (!keyReady)
		else
		begin
			$display("keyReady still high while the round keys expand");
			otherCount++;
		end
	endtask

	task automatic pushBlock(input int idx);
		inValid = 1'b1;
		inData = vecBlk[idx];
		inDecrypt = (vecOp[idx] == 1);
		@(posedge clkAll);
		while (!inReady)
		begin
			fullSeen = 1'b1;
			@(posedge clkAll);
		end
		expQ.push_back(vecExp[idx]);
		nameQ.push_back($sformatf("vec%0d_%s", idx, (vecOp[idx] == 1) ? "dec" : "enc"));
		@(negedge clkAll);
		inValid = 1'b0;
	endtask

	task automatic printCounts();
		$display("Summary: %0d mismatches, %0d other errors, %0d of %0d results checked",
			mismatchCount, otherCount, checkedCount, blockCount);
	endtask

	// Sink stalls for random stretches
	initial
	begin : readyDriver
		int len;
		outReady = 1'b0;
		forever
		begin
			len = 1 + ($unsigned($random(seed)) % 8);
			repeat (len)
				@(negedge clkAll);
			outReady = !outReady;
		end
	end

	always @(posedge clkAll)
	begin : monitor
		logic [blkBits-1:0] expd;
		string name;
		if (nR && outValid)
		begin
			assert (!keyReady)
			else
			begin
				$display("keyReady high while the engine holds a result");
				otherCount++;
			end
		end
		if (nR && outValid && outReady)
		begin
			assert (expQ.size() != 0)
			else
			begin
				$display("Result delivered with no block pending");
				otherCount++;
			end
			if (expQ.size() != 0)
			begin
				expd = expQ.pop_front();
				name = nameQ.pop_front();
				checkedCount++;
				assert (outData === expd)
				else
				begin
					$display("Mismatch %s expected %h actual %h", name, expd, outData);
					mismatchCount++;
				end
			end
		end
	end

	initial
	begin : watchdog
		int limit;
		wait (vectorsRead);
		// Per vector budget plus one expansion per key
		limit = vecOp.size() * 60 + keyCount * `SIMON_ROUNDS + 10;
		repeat (limit)
			@(posedge clkAll);
		$display("Timeout after %0d cycles with %0d results still pending", limit, expQ.size());
		printCounts();
		$display("Test FAILED");
		$finish;
	end

	initial
	begin : mainFlow
		logic [keyBits-1:0] curKey;
		bit haveKey;
		nR = 1'b0;
		keyValid = 1'b0;
		key = '0;
		inValid = 1'b0;
		inData = '0;
		inDecrypt = 1'b0;
		haveKey = 1'b0;
		curKey = '0;
		readVectors();
		vectorsRead = 1'b1;
		repeat (3)
			@(posedge clkAll);
		@(negedge clkAll);
		nR = 1'b1;
		assert (keyReady && inReady && !outValid)
		else
		begin
			$display("Wrong handshake levels after reset");
			otherCount++;
		end
		for (int i = 0; i < vecOp.size(); i++)
		begin
			if (!haveKey || vecKey[i] != curKey)
			begin
				loadKey(vecKey[i]);
				curKey = vecKey[i];
				haveKey = 1'b1;
			end
			if (vecOp[i] != 2)
				pushBlock(i);
		end
		while (expQ.size() != 0)
			@(negedge clkAll);
		repeat (3)
			@(negedge clkAll);
		assert (vecOp.size() != 0 && checkedCount == blockCount)
		else
		begin
			$display("Only %0d of %0d results were checked", checkedCount, blockCount);
			otherCount++;
		end
		assert (fullSeen)
		else
		begin
			$display("inReady never fell, the FIFO was never full");
			otherCount++;
		end
		printCounts();
		if (mismatchCount == 0 && otherCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* design/simonCore.sv */
`timescale 1ns/1ps
`include "simon_cfg.svh"

module simonCore
(
	input logic clkAll,
	input logic nR,
	input logic keyValid,
	output logic keyReady,
	input logic [`SIMON_KEY_WORDS-1:0][`SIMON_WORD-1:0] key,
	input logic inValid,
	output logic inReady,
	input logic [2*`SIMON_WORD-1:0] inData,
	input logic inDecrypt,
	output logic outValid,
	input logic outReady,
	output logic [2*`SIMON_WORD-1:0] outData
);

	logic [4:0] keyIndex;
	logic [`SIMON_WORD-1:0] roundKey;
	logic keysReady;
	logic engineBusy;

	blockIf inLink();
	blockIf queueLink();

	assign inLink.valid = inValid;
	assign inLink.data = inData;
	assign inLink.op = inDecrypt ? simonPkg::opDecrypt : simonPkg::opEncrypt;
	assign inReady = inLink.ready;

	simonKeySchedule keySchedule
	(
		.clkAll(clkAll),
		.nR(nR),
		.keyValid(keyValid),
		.keyReady(keyReady),
		.key(key),
		.engineBusy(engineBusy),
		.keyIndex(keyIndex),
		.roundKey(roundKey),
		.keysReady(keysReady)
	);

	simonBlockFifo blockFifo
	(
		.clkAll(clkAll),
		.nR(nR),
		.pushSide(inLink.sink),
		.popSide(queueLink.source)
	);

	simonRoundEngine roundEngine
	(
		.clkAll(clkAll),
		.nR(nR),
		.blockIn(queueLink.sink),
		.keysReady(keysReady),
		.keyIndex(keyIndex),
		.roundKey(roundKey),
		.engineBusy(engineBusy),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

endmodule

/* design/simonRoundEngine.sv */
`timescale 1ns/1ps
`include "simon_cfg.svh"

module simonRoundEngine
(
	input logic clkAll,
	input logic nR,
	blockIf.sink blockIn,
	input logic keysReady,
	output logic [4:0] keyIndex,
	input logic [`SIMON_WORD-1:0] roundKey,
	output logic engineBusy,
	output logic outValid,
	input logic outReady,
	output logic [2*`SIMON_WORD-1:0] outData
);

	localparam logic [4:0] lastRound = 5'(`SIMON_ROUNDS - 1);

	simonPkg::engineState state;
	simonPkg::cipherOp curOp;
	logic [4:0] roundCnt;
	logic [2*`SIMON_WORD-1:0] work;
	logic accept;
	logic isDec;

	assign blockIn.ready = (state == simonPkg::esIdle) && keysReady;
	assign accept = blockIn.valid && blockIn.ready;
	assign engineBusy = (state != simonPkg::esIdle);
	assign isDec = (curOp == simonPkg::opDecrypt);

	// Decryption walks the key store backwards
	assign keyIndex = isDec ? (lastRound - roundCnt) : roundCnt;

	always_ff @(posedge clkAll, negedge nR)
	begin
		if (!nR)
		begin
			state <= simonPkg::esIdle;
			curOp <= simonPkg::opEncrypt;
			roundCnt <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			unique case (state)
			simonPkg::esIdle:
			begin
				if (accept)
				begin
					state <= simonPkg::esRound;
					curOp <= blockIn.op;
					roundCnt <= '0;
				end
			end
			simonPkg::esRound:
			begin
				roundCnt <= roundCnt + 5'd1;
				if (roundCnt == lastRound)
					state <= simonPkg::esHold;
			end
			simonPkg::esHold:
			begin
				// One cycle to fill the hold register, then wait for the sink
				if (!outValid)
					outValid <= 1'b1;
				else if (outReady)
				begin
					outValid <= 1'b0;
					state <= simonPkg::esIdle;
				end
			end
			default:
				state <= simonPkg::esIdle;
			endcase
		end
	end

	always_ff @(posedge clkAll)
	begin
		if (accept)
		begin
			if (blockIn.op == simonPkg::opDecrypt)
				work <= {blockIn.data[`SIMON_WORD-1:0], blockIn.data[2*`SIMON_WORD-1:`SIMON_WORD]};
			else
				work <= blockIn.data;
		end
		else if (state == simonPkg::esRound)
			work <= simonPkg::simonRound(work, roundKey);

		if ((state == simonPkg::esHold) && !outValid)
			outData <= isDec ? {work[`SIMON_WORD-1:0], work[2*`SIMON_WORD-1:`SIMON_WORD]} : work;
	end

	holdStable: assert property (@(posedge clkAll) disable iff (!nR)
		(outValid && !outReady) |=> (outValid && $stable(outData)));

endmodule

/* design/simonBlockFifo.sv */
`timescale 1ns/1ps
`include "simon_cfg.svh"

module simonBlockFifo
(
	input logic clkAll,
	input logic nR,
	blockIf.sink pushSide,
	blockIf.source popSide
);

	localparam int ptrBits = $clog2(`SIMON_FIFO_DEPTH);
	localparam logic [ptrBits:0] fullCount = (ptrBits + 1)'(`SIMON_FIFO_DEPTH);

	logic [2*`SIMON_WORD-1:0] dataMem [`SIMON_FIFO_DEPTH];
	simonPkg::cipherOp opMem [`SIMON_FIFO_DEPTH];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [ptrBits:0] count;
	logic doPush;
	logic doPop;

	assign pushSide.ready = (count != fullCount);
	assign popSide.valid = (count != '0);
	assign popSide.data = dataMem[rdPtr];
	assign popSide.op = opMem[rdPtr];

	assign doPush = pushSide.valid && pushSide.ready;
	assign doPop = popSide.valid && popSide.ready;

	always_ff @(posedge clkAll, negedge nR)
	begin
		if (!nR)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap on their own since the depth is a power of two
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			unique case ({doPush, doPop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clkAll)
	begin
		if (doPush)
		begin
			dataMem[wrPtr] <= pushSide.data;
			opMem[wrPtr] <= pushSide.op;
		end
	end

	// Occupancy stays within the depth and agrees with the pointers
	occupancyBound: assert property (@(posedge clkAll) disable iff (!nR)
		(count <= fullCount) && (count[ptrBits-1:0] == wrPtr - rdPtr));

endmodule

/* design/simonKeySchedule.sv */
`timescale 1ns/1ps
`include "simon_cfg.svh"

module simonKeySchedule
(
	input logic clkAll,
	input logic nR,
	input logic keyValid,
	output logic keyReady,
	input logic [`SIMON_KEY_WORDS-1:0][`SIMON_WORD-1:0] key,
	input logic engineBusy,
	input logic [4:0] keyIndex,
	output logic [`SIMON_WORD-1:0] roundKey,
	output logic keysReady
);

	localparam logic [4:0] firstIdx = 5'(`SIMON_KEY_WORDS);
	localparam logic [4:0] lastIdx = 5'(`SIMON_ROUNDS - 1);

	simonPkg::keyState state;
	logic [4:0] expIdx;
	logic [`SIMON_WORD-1:0] keyStore [`SIMON_ROUNDS];
	logic [`SIMON_KEY_WORDS-1:0][`SIMON_WORD-1:0] window;
	logic [`SIMON_WORD-1:0] nextKey;
	logic keyTake;

	// Never swap keys under a running block
	assign keyReady = (state != simonPkg::ksExpand) && !engineBusy;
	assign keyTake = keyValid && keyReady;
	// A key being loaded wins over a waiting block
	assign keysReady = (state == simonPkg::ksReady) && !keyTake;
	assign roundKey = keyStore[keyIndex];
	assign nextKey = simonPkg::keyStep(window, int'(expIdx));

	always_ff @(posedge clkAll, negedge nR)
	begin
		if (!nR)
		begin
			state <= simonPkg::ksIdle;
			expIdx <= firstIdx;
		end
		else
		begin
			unique case (state)
			simonPkg::ksIdle, simonPkg::ksReady:
			begin
				if (keyTake)
				begin
					state <= simonPkg::ksExpand;
					expIdx <= firstIdx;
				end
			end
			simonPkg::ksExpand:
			begin
				expIdx <= expIdx + 5'd1;
				if (expIdx == lastIdx)
					state <= simonPkg::ksReady;
			end
			default:
				state <= simonPkg::ksIdle;
			endcase
		end
	end

	// Key store and sliding window of the last four round keys
	always_ff @(posedge clkAll)
	begin
		if (keyTake)
		begin
			window <= key;
			for (int i = 0; i < `SIMON_KEY_WORDS; i++)
				keyStore[i] <= key[i];
		end
		else if (state == simonPkg::ksExpand)
		begin
			keyStore[expIdx] <= nextKey;
			window <= {nextKey, window[`SIMON_KEY_WORDS-1:1]};
		end
	end

	// Engine cannot start in the cycle after a new key
	keyIdleAtLoad: assert property (@(posedge clkAll) disable iff (!nR)
		(keyValid && keyReady) |=> !engineBusy);

endmodule

/* design/blockIf.sv */
`timescale 1ns/1ps
`include "simon_cfg.svh"

interface blockIf;

	logic valid;
	logic ready;
	logic [2*`SIMON_WORD-1:0] data;
	simonPkg::cipherOp op;

	modport source
	(
		output valid,
		output data,
		output op,
		input ready
	);

	modport sink
	(
		input valid,
		input data,
		input op,
		output ready
	);

endinterface

/* design/simonPkg.sv */
`include "simon_cfg.svh"

package simonPkg;

	typedef enum logic {opEncrypt, opDecrypt} cipherOp;

	typedef enum logic [1:0] {ksIdle, ksExpand, ksReady} keyState;

	typedef enum logic [1:0] {esIdle, esRound, esHold} engineState;

	localparam logic [61:0] zSeq = `SIMON_Z0;

	// One Feistel round with x in the upper word
	function automatic logic [2*`SIMON_WORD-1:0] simonRound(
		input logic [2*`SIMON_WORD-1:0] blk,
		input logic [`SIMON_WORD-1:0] rk);
		logic [`SIMON_WORD-1:0] x;
		logic [`SIMON_WORD-1:0] y;
		logic [`SIMON_WORD-1:0] f;
		x = blk[2*`SIMON_WORD-1:`SIMON_WORD];
		y = blk[`SIMON_WORD-1:0];
		f = ({x[`SIMON_WORD-2:0], x[`SIMON_WORD-1]}
			& {x[`SIMON_WORD-9:0], x[`SIMON_WORD-1:`SIMON_WORD-8]})
			^ {x[`SIMON_WORD-3:0], x[`SIMON_WORD-1:`SIMON_WORD-2]};
		return {y ^ f ^ rk, x};
	endfunction

	// prev[3] is k[i-1] and prev[0] is k[i-4]
	function automatic logic [`SIMON_WORD-1:0] keyStep(
		input logic [`SIMON_KEY_WORDS-1:0][`SIMON_WORD-1:0] prev,
		input int idx);
		logic [`SIMON_WORD-1:0] tmp;
		logic zBit;
		tmp = {prev[`SIMON_KEY_WORDS-1][2:0], prev[`SIMON_KEY_WORDS-1][`SIMON_WORD-1:3]}
			^ prev[1];
		tmp = tmp ^ {tmp[0], tmp[`SIMON_WORD-1:1]};
		zBit = zSeq[(idx - `SIMON_KEY_WORDS) % 62];
		// ~k ^ 3 folded into the constant
		return prev[0] ^ tmp ^ {{(`SIMON_WORD-2){1'b1}}, 1'b0, zBit};
	endfunction

endpackage

/* include/simon_cfg.svh */
`ifndef SIMON_CFG_SVH
`define SIMON_CFG_SVH

// SIMON 32/64 geometry
`define SIMON_WORD 16
`define SIMON_KEY_WORDS 4
`define SIMON_ROUNDS 32

// Block FIFO entries as a power of two
`define SIMON_FIFO_DEPTH 4

// z0 sequence with element j in bit j
`define SIMON_Z0 62'h19C3522FB386A45F

`endif
